// File: Bender.yml
package:
  name: ex_stage

sources:
  - verilog/exe_pkg.sv
  - verilog/ex_arith.sv
  - verilog/ex_mult.sv
  - verilog/ex.sv
  - verilog/ex_mem.sv
  - verilog/ex_stage.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/ex_stage_properties.sv
      - bench/tb_ex_stage.sv

// File: bench/clk_gen.sv
module clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;   // Period of 10.

endmodule

// File: bench/ex_stage_properties.sv
module ex_stage_properties (
    input logic             clk_i,
    input logic             rst_i,
    input exe_pkg::ex_req_t ex_req_i,
    input exe_pkg::wb_req_t wb_i,
    input exe_pkg::hilo_t   hilo_i
);

    int unsigned fail_count = 0;
    logic [32:0] add_wide;
    logic [32:0] sub_wide;
    logic        ovf_in;
    logic        hilo_req;

    // Sign-extended sum and difference of the presented operands.
    assign add_wide = {ex_req_i.reg1[31], ex_req_i.reg1} + {ex_req_i.reg2[31], ex_req_i.reg2};
    assign sub_wide = {ex_req_i.reg1[31], ex_req_i.reg1} - {ex_req_i.reg2[31], ex_req_i.reg2};

    always_comb begin
        case (ex_req_i.aluop)
            exe_pkg::OP_ADD, exe_pkg::OP_ADDI: ovf_in = add_wide[32] ^ add_wide[31];
            exe_pkg::OP_SUB:                   ovf_in = sub_wide[32] ^ sub_wide[31];
            default:                           ovf_in = 1'b0;
        endcase
    end

    assign hilo_req = ex_req_i.aluop inside {exe_pkg::OP_MULT, exe_pkg::OP_MULTU,
                                             exe_pkg::OP_MTHI, exe_pkg::OP_MTLO};

    // ************************************************************
    // Stage timing.
    // ************************************************************
    reset_wreg: assert property (@(posedge clk_i) rst_i |=> !wb_i.wreg)
        else begin
            fail_count++;
            $error("wreg set in the cycle after reset");
        end

    ovf_cancel: assert property (@(posedge clk_i) disable iff (rst_i) ovf_in |=> !wb_i.wreg)
        else begin
            fail_count++;
            $error("wreg set after an overflowing add or subtract");
        end

    // HI/LO moves only when a request registered one edge before.
    hilo_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(hilo_i) |-> $past(rst_i) || ($past(hilo_req, 2) && !$past(rst_i, 2)))
        else begin
            fail_count++;
            $error("hilo changed without a registered write request");
        end

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk_i    (clk),
    .rst_i    (rst_i),
    .ex_req_i (ex_req_i),
    .wb_i     (wb_o),
    .hilo_i   (hilo_o)
);

// File: bench/tb_ex_stage.sv
module tb_ex_stage;

    logic             clk;
    logic             rst_i;
    exe_pkg::ex_req_t ex_req_i;
    exe_pkg::wb_req_t wb_o;
    exe_pkg::hilo_t   hilo_o;

    int unsigned lcg_state   = 5;
    int          wb_errors   = 0;
    int          hilo_errors = 0;

    exe_pkg::alu_op_e op_table [39] = '{
        exe_pkg::OP_NOP, exe_pkg::OP_AND, exe_pkg::OP_OR, exe_pkg::OP_XOR, exe_pkg::OP_NOR,
        exe_pkg::OP_ANDI, exe_pkg::OP_ORI, exe_pkg::OP_XORI, exe_pkg::OP_SLL, exe_pkg::OP_SLLV,
        exe_pkg::OP_SRL, exe_pkg::OP_SRLV, exe_pkg::OP_SRA, exe_pkg::OP_SRAV, exe_pkg::OP_MOVZ,
        exe_pkg::OP_MOVN, exe_pkg::OP_MFHI, exe_pkg::OP_MTHI, exe_pkg::OP_MFLO, exe_pkg::OP_MTLO,
        exe_pkg::OP_SLT, exe_pkg::OP_SLTU, exe_pkg::OP_SLTI, exe_pkg::OP_SLTIU, exe_pkg::OP_ADD,
        exe_pkg::OP_ADDU, exe_pkg::OP_SUB, exe_pkg::OP_SUBU, exe_pkg::OP_ADDI, exe_pkg::OP_ADDIU,
        exe_pkg::OP_CLZ, exe_pkg::OP_CLO, exe_pkg::OP_MULT, exe_pkg::OP_MULTU, exe_pkg::OP_MUL,
        exe_pkg::OP_JAL, exe_pkg::OP_JALR, exe_pkg::OP_BLTZAL, exe_pkg::OP_BGEZAL
    };

    clk_gen u_clk_gen (
        .clk_o (clk)
    );

    ex_stage DUT (
        .clk      (clk),
        .rst_i    (rst_i),
        .ex_req_i (ex_req_i),
        .wb_o     (wb_o),
        .hilo_o   (hilo_o)
    );

    // ************************************************************
    // Stimulus helpers.
    // ************************************************************
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic exe_pkg::word_t draw_word();
        int unsigned hi;
        int unsigned lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};   // Upper bits are the better ones.
    endfunction

    // Edge operands for 5 draws out of 16.
    function automatic exe_pkg::word_t draw_operand();
        int unsigned pick;
        pick = lcg_next() >> 28;
        case (pick)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'h0000_001f;
            default: return draw_word();
        endcase
    endfunction

    function automatic exe_pkg::alu_sel_e class_of(input exe_pkg::alu_op_e op);
        case (op)
            exe_pkg::OP_AND, exe_pkg::OP_OR, exe_pkg::OP_XOR, exe_pkg::OP_NOR,
            exe_pkg::OP_ANDI, exe_pkg::OP_ORI, exe_pkg::OP_XORI: return exe_pkg::SEL_LOGIC;
            exe_pkg::OP_SLL, exe_pkg::OP_SLLV, exe_pkg::OP_SRL, exe_pkg::OP_SRLV,
            exe_pkg::OP_SRA, exe_pkg::OP_SRAV: return exe_pkg::SEL_SHIFT;
            exe_pkg::OP_MOVZ, exe_pkg::OP_MOVN,
            exe_pkg::OP_MFHI, exe_pkg::OP_MFLO: return exe_pkg::SEL_MOVE;
            exe_pkg::OP_SLT, exe_pkg::OP_SLTU, exe_pkg::OP_SLTI, exe_pkg::OP_SLTIU,
            exe_pkg::OP_ADD, exe_pkg::OP_ADDU, exe_pkg::OP_SUB, exe_pkg::OP_SUBU,
            exe_pkg::OP_ADDI, exe_pkg::OP_ADDIU,
            exe_pkg::OP_CLZ, exe_pkg::OP_CLO: return exe_pkg::SEL_ARITHMETIC;
            exe_pkg::OP_MUL: return exe_pkg::SEL_MUL;
            exe_pkg::OP_JAL, exe_pkg::OP_JALR,
            exe_pkg::OP_BLTZAL, exe_pkg::OP_BGEZAL: return exe_pkg::SEL_JUMP_BRANCH;
            default: return exe_pkg::SEL_NOP;
        endcase
    endfunction

    function automatic int count_lead(input exe_pkg::word_t w, input logic bit_val);
        int n;
        n = 0;
        while (n < 32 && w[31-n] == bit_val) begin
            n++;
        end
        return n;
    endfunction

    // ************************************************************
    // Reference model.
    // ************************************************************
    task automatic predict(
        input  exe_pkg::ex_req_t  req,
        input  exe_pkg::hilo_t    fwd,
        output exe_pkg::wb_req_t  wb,
        output exe_pkg::hilo_wr_t wr
    );
        exe_pkg::word_t a;
        exe_pkg::word_t b;
        exe_pkg::word_t res;
        logic [32:0]    wide;
        logic           ovf;
        a    = req.reg1;
        b    = req.reg2;
        res  = '0;
        ovf  = 1'b0;
        wr   = '0;
        wide = {a[31], a} + {b[31], b};
        case (req.aluop)
            exe_pkg::OP_OR, exe_pkg::OP_ORI:     res = a | b;
            exe_pkg::OP_AND, exe_pkg::OP_ANDI:   res = a & b;
            exe_pkg::OP_XOR, exe_pkg::OP_XORI:   res = a ^ b;
            exe_pkg::OP_NOR:                     res = ~(a | b);
            exe_pkg::OP_SLL, exe_pkg::OP_SLLV:   res = b << a[4:0];
            exe_pkg::OP_SRL, exe_pkg::OP_SRLV:   res = b >> a[4:0];
            exe_pkg::OP_SRA, exe_pkg::OP_SRAV:   res = $signed(b) >>> a[4:0];
            exe_pkg::OP_MFHI:                    res = fwd.hi;
            exe_pkg::OP_MFLO:                    res = fwd.lo;
            exe_pkg::OP_MOVN, exe_pkg::OP_MOVZ:  res = a;
            exe_pkg::OP_ADDU, exe_pkg::OP_ADDIU: res = a + b;
            exe_pkg::OP_SUBU:                    res = a - b;
            exe_pkg::OP_SLT, exe_pkg::OP_SLTI:   res = {31'b0, $signed(a) < $signed(b)};
            exe_pkg::OP_SLTU, exe_pkg::OP_SLTIU: res = {31'b0, a < b};
            exe_pkg::OP_CLZ:                     res = count_lead(a, 1'b0);
            exe_pkg::OP_CLO:                     res = count_lead(a, 1'b1);
            exe_pkg::OP_MUL:                     res = a * b;   // Low word is sign blind.
            exe_pkg::OP_ADD, exe_pkg::OP_ADDI: begin
                res = a + b;
                ovf = wide[32] ^ wide[31];
            end
            exe_pkg::OP_SUB: begin
                wide = {a[31], a} - {b[31], b};
                res  = a - b;
                ovf  = wide[32] ^ wide[31];
            end
            exe_pkg::OP_MULT: begin
                wr.we         = 1'b1;
                {wr.hi, wr.lo} = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            end
            exe_pkg::OP_MULTU: begin
                wr.we         = 1'b1;
                {wr.hi, wr.lo} = {32'b0, a} * {32'b0, b};
            end
            exe_pkg::OP_MTHI: wr = {1'b1, a, fwd.lo};
            exe_pkg::OP_MTLO: wr = {1'b1, fwd.hi, a};
            default: ;
        endcase
        wb.wd   = req.wd;
        wb.wreg = req.wreg & ~ovf;
        case (req.alusel)
            exe_pkg::SEL_NOP:         wb.wdata = '0;
            exe_pkg::SEL_JUMP_BRANCH: wb.wdata = req.link_addr;
            default:                  wb.wdata = res;
        endcase
    endtask

    task automatic check_wb(
        input string            name,
        input exe_pkg::wb_req_t exp,
        input exe_pkg::wb_req_t act
    );
        if (act !== exp) begin
            wb_errors++;
            $display("ERR %s: expected wd=%0d wreg=%b wdata=%h, actual wd=%0d wreg=%b wdata=%h",
                     name, exp.wd, exp.wreg, exp.wdata, act.wd, act.wreg, act.wdata);
        end
    endtask

    task automatic check_hilo(
        input string          name,
        input exe_pkg::hilo_t exp,
        input exe_pkg::hilo_t act
    );
        if (act !== exp) begin
            hilo_errors++;
            $display("ERR %s: expected hi=%h lo=%h, actual hi=%h lo=%h",
                     name, exp.hi, exp.lo, act.hi, act.lo);
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (rst_i !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        released = (rst_i === 1'b0);
    endtask

    task automatic run_random(input int count);
        exe_pkg::ex_req_t  req;
        exe_pkg::wb_req_t  exp_wb;
        exe_pkg::hilo_wr_t next_wr;
        exe_pkg::hilo_wr_t reg_wr;
        exe_pkg::hilo_t    model_hilo;
        exe_pkg::hilo_t    fwd;
        string             exp_name;
        int unsigned       idx;
        exp_wb     = '0;
        next_wr    = '0;
        reg_wr     = '0;
        model_hilo = '0;
        exp_name   = "reset";
        repeat (count) begin
            @(posedge clk);
            #1;
            if (reg_wr.we) begin
                model_hilo = {reg_wr.hi, reg_wr.lo};   // Commits one edge after it registers.
            end
            reg_wr = next_wr;
            check_wb(exp_name, exp_wb, wb_o);
            check_hilo("hilo", model_hilo, hilo_o);
            fwd = reg_wr.we ? {reg_wr.hi, reg_wr.lo} : model_hilo;
            idx           = (lcg_next() >> 16) % 39;
            req.aluop     = op_table[idx];
            req.alusel    = class_of(req.aluop);
            req.reg1      = draw_operand();
            req.reg2      = draw_operand();
            req.wd        = exe_pkg::reg_addr_t'(lcg_next() >> 27);
            req.wreg      = (lcg_next() >> 30) != 0;
            req.link_addr = draw_word();
            predict(req, fwd, exp_wb, next_wr);
            exp_name = req.aluop.name();
            ex_req_i = req;
        end
    endtask

    // Reset for two cycles, with a live HI write held on the inputs.
    initial begin
        rst_i         = 1'b1;
        ex_req_i      = '0;
        ex_req_i.aluop = exe_pkg::OP_MTHI;
        ex_req_i.reg1 = '1;
        ex_req_i.wd   = 5'd31;
        ex_req_i.wreg = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_i    = 1'b0;
        ex_req_i = '0;
    end

    initial begin
        logic released;
        wait_reset_release(released);
        if (!released) begin
            $display("Timed out waiting for reset release.");
            $display("TESTS FAILED");
        end else begin
            run_random(4000);
            $display("Errors: wb %0d, hilo %0d, assertions %0d",
                     wb_errors, hilo_errors, DUT.u_props.fail_count);
            if (wb_errors + hilo_errors + DUT.u_props.fail_count == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

// File: ex_stage.f
verilog/exe_pkg.sv
verilog/ex_arith.sv
verilog/ex_mult.sv
verilog/ex.sv
verilog/ex_mem.sv
verilog/ex_stage.sv
bench/clk_gen.sv
bench/ex_stage_properties.sv
bench/tb_ex_stage.sv

// File: verilog/ex.sv
module ex (
    input  exe_pkg::ex_req_t  req_i,
    input  exe_pkg::hilo_t    hilo_fwd_i,
    output exe_pkg::wb_req_t  wb_o,
    output exe_pkg::hilo_wr_t hilo_wr_o
);

    exe_pkg::word_t  logic_res;
    exe_pkg::word_t  shift_res;
    exe_pkg::word_t  move_res;
    exe_pkg::word_t  arith_res;
    exe_pkg::dword_t product;
    exe_pkg::shamt_t shamt;
    logic            arith_ovf;

    ex_arith u_arith (
        .aluop_i  (req_i.aluop),
        .reg1_i   (req_i.reg1),
        .reg2_i   (req_i.reg2),
        .result_o (arith_res),
        .ovf_o    (arith_ovf)
    );

    ex_mult u_mult (
        .aluop_i   (req_i.aluop),
        .reg1_i    (req_i.reg1),
        .reg2_i    (req_i.reg2),
        .product_o (product)
    );

    // **********************************************************
    // Logic, shift and move results.
    // **********************************************************
    always_comb begin
        case (req_i.aluop)
            exe_pkg::OP_OR,  exe_pkg::OP_ORI:  logic_res = req_i.reg1 | req_i.reg2;
            exe_pkg::OP_AND, exe_pkg::OP_ANDI: logic_res = req_i.reg1 & req_i.reg2;
            exe_pkg::OP_XOR, exe_pkg::OP_XORI: logic_res = req_i.reg1 ^ req_i.reg2;
            exe_pkg::OP_NOR:                   logic_res = ~(req_i.reg1 | req_i.reg2);
            default:                           logic_res = '0;
        endcase
    end

    assign shamt = req_i.reg1[exe_pkg::SHAMT_W-1:0];  // Amount from reg1, data in reg2.

    always_comb begin
        case (req_i.aluop)
            exe_pkg::OP_SLL, exe_pkg::OP_SLLV: shift_res = req_i.reg2 << shamt;
            exe_pkg::OP_SRL, exe_pkg::OP_SRLV: shift_res = req_i.reg2 >> shamt;
            exe_pkg::OP_SRA, exe_pkg::OP_SRAV: begin
                shift_res = exe_pkg::word_t'($signed(req_i.reg2) >>> shamt);
            end
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.aluop)
            exe_pkg::OP_MFHI:                  move_res = hilo_fwd_i.hi;
            exe_pkg::OP_MFLO:                  move_res = hilo_fwd_i.lo;
            exe_pkg::OP_MOVN, exe_pkg::OP_MOVZ: move_res = req_i.reg1;
            default:                           move_res = '0;
        endcase
    end

    // **********************************************************
    // Write-back select.
    // **********************************************************
    always_comb begin
        wb_o.wd   = req_i.wd;
        wb_o.wreg = req_i.wreg & ~arith_ovf;   // Overflow cancels the write.
        case (req_i.alusel)
            exe_pkg::SEL_LOGIC:       wb_o.wdata = logic_res;
            exe_pkg::SEL_SHIFT:       wb_o.wdata = shift_res;
            exe_pkg::SEL_MOVE:        wb_o.wdata = move_res;
            exe_pkg::SEL_ARITHMETIC:  wb_o.wdata = arith_res;
            exe_pkg::SEL_MUL:         wb_o.wdata = product[exe_pkg::WORD_W-1:0];
            exe_pkg::SEL_JUMP_BRANCH: wb_o.wdata = req_i.link_addr;
            default:                  wb_o.wdata = '0;
        endcase
    end

    // HI/LO write request.
    always_comb begin
        hilo_wr_o = '0;
        case (req_i.aluop)
            exe_pkg::OP_MULT, exe_pkg::OP_MULTU: begin
                hilo_wr_o.we = 1'b1;
                hilo_wr_o.hi = product[exe_pkg::DWORD_W-1:exe_pkg::WORD_W];
                hilo_wr_o.lo = product[exe_pkg::WORD_W-1:0];
            end
            exe_pkg::OP_MTHI: begin
                hilo_wr_o.we = 1'b1;
                hilo_wr_o.hi = req_i.reg1;
                hilo_wr_o.lo = hilo_fwd_i.lo;   // Keep the other half.
            end
            exe_pkg::OP_MTLO: begin
                hilo_wr_o.we = 1'b1;
                hilo_wr_o.hi = hilo_fwd_i.hi;
                hilo_wr_o.lo = req_i.reg1;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/ex_arith.sv
module ex_arith (
    input  exe_pkg::alu_op_e aluop_i,
    input  exe_pkg::word_t   reg1_i,
    input  exe_pkg::word_t   reg2_i,
    output exe_pkg::word_t   result_o,
    output logic             ovf_o
);

    // Leading zeros, scanned from the MSB down.
    function automatic exe_pkg::word_t lead_zeros(input exe_pkg::word_t w);
        exe_pkg::word_t cnt;
        logic           found;
        cnt   = '0;
        found = 1'b0;
        for (int i = exe_pkg::WORD_W - 1; i >= 0; i--) begin
            if (w[i]) begin
                found = 1'b1;
            end else if (!found) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    logic           is_sub;
    logic           raw_ovf;
    logic           signed_lt;
    logic           unsigned_lt;
    exe_pkg::word_t operand2;
    exe_pkg::word_t sum;

    always_comb begin
        case (aluop_i)
            exe_pkg::OP_SUB, exe_pkg::OP_SUBU,
            exe_pkg::OP_SLT, exe_pkg::OP_SLTI: is_sub = 1'b1;
            default:                           is_sub = 1'b0;
        endcase
    end

    // Subtract as reg1 + ~reg2 + 1.
    assign operand2 = is_sub ? ~reg2_i : reg2_i;
    assign sum      = reg1_i + operand2 + exe_pkg::word_t'(is_sub);

    // Same sign in, other sign out.
    assign raw_ovf = (reg1_i[exe_pkg::WORD_W-1] == operand2[exe_pkg::WORD_W-1]) &&
                     (sum[exe_pkg::WORD_W-1] != reg1_i[exe_pkg::WORD_W-1]);

    assign signed_lt   = sum[exe_pkg::WORD_W-1] ^ raw_ovf;  // Sign of the true difference.
    assign unsigned_lt = reg1_i < reg2_i;

    always_comb begin
        case (aluop_i)
            exe_pkg::OP_ADD, exe_pkg::OP_ADDI, exe_pkg::OP_SUB: ovf_o = raw_ovf;
            default:                                            ovf_o = 1'b0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            exe_pkg::OP_ADD, exe_pkg::OP_ADDU, exe_pkg::OP_ADDI, exe_pkg::OP_ADDIU,
            exe_pkg::OP_SUB, exe_pkg::OP_SUBU: begin
                result_o = sum;
            end
            exe_pkg::OP_SLT, exe_pkg::OP_SLTI: begin
                result_o = exe_pkg::word_t'(signed_lt);
            end
            exe_pkg::OP_SLTU, exe_pkg::OP_SLTIU: begin
                result_o = exe_pkg::word_t'(unsigned_lt);
            end
            exe_pkg::OP_CLZ: result_o = lead_zeros(reg1_i);
            exe_pkg::OP_CLO: result_o = lead_zeros(~reg1_i);   // Ones become zeros.
            default:         result_o = '0;
        endcase
    end

endmodule

// File: verilog/ex_mem.sv
module ex_mem (
    input  logic              clk,
    input  logic              rst_i,
    input  exe_pkg::wb_req_t  wb_i,
    input  exe_pkg::hilo_wr_t hilo_wr_i,
    output exe_pkg::wb_req_t  wb_o,
    output exe_pkg::hilo_t    hilo_o,
    output exe_pkg::hilo_t    hilo_fwd_o
);

    exe_pkg::wb_req_t  wb_q;
    exe_pkg::hilo_wr_t hilo_wr_q;
    exe_pkg::hilo_t    hilo_q;

    // **********************************************************
    // Execute to memory register.
    // **********************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q      <= '0;
            hilo_wr_q <= '0;
        end else begin
            wb_q      <= wb_i;
            hilo_wr_q <= hilo_wr_i;
        end
    end

    // Architectural HI/LO, one edge behind its request.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_q <= '0;
        end else if (hilo_wr_q.we) begin
            hilo_q.hi <= hilo_wr_q.hi;
            hilo_q.lo <= hilo_wr_q.lo;
        end
    end

    // A pending write wins over the stored pair.
    always_comb begin
        if (hilo_wr_q.we) begin
            hilo_fwd_o.hi = hilo_wr_q.hi;
            hilo_fwd_o.lo = hilo_wr_q.lo;
        end else begin
            hilo_fwd_o = hilo_q;
        end
    end

    assign wb_o   = wb_q;
    assign hilo_o = hilo_q;

endmodule

// File: verilog/ex_mult.sv
module ex_mult (
    input  exe_pkg::alu_op_e aluop_i,
    input  exe_pkg::word_t   reg1_i,
    input  exe_pkg::word_t   reg2_i,
    output exe_pkg::dword_t  product_o
);

    logic            is_signed;
    logic            neg_result;
    exe_pkg::word_t  mag1;
    exe_pkg::word_t  mag2;
    exe_pkg::dword_t mag_product;

    assign is_signed = (aluop_i == exe_pkg::OP_MUL) || (aluop_i == exe_pkg::OP_MULT);

    // Magnitudes of signed operands.
    assign mag1 = (is_signed && reg1_i[exe_pkg::WORD_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2 = (is_signed && reg2_i[exe_pkg::WORD_W-1]) ? (~reg2_i + 1'b1) : reg2_i;

    assign mag_product = exe_pkg::dword_t'(mag1) * exe_pkg::dword_t'(mag2);

    // Opposite signs give a negative product.
    assign neg_result = is_signed &&
                        (reg1_i[exe_pkg::WORD_W-1] ^ reg2_i[exe_pkg::WORD_W-1]);

    assign product_o = neg_result ? (~mag_product + 1'b1) : mag_product;

endmodule

// File: verilog/ex_stage.sv
module ex_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  exe_pkg::ex_req_t ex_req_i,
    output exe_pkg::wb_req_t wb_o,
    output exe_pkg::hilo_t   hilo_o
);

    exe_pkg::wb_req_t  ex_wb;
    exe_pkg::hilo_wr_t ex_hilo_wr;
    exe_pkg::hilo_t    hilo_fwd;

    // Combinational execute.
    ex u_ex (
        .req_i      (ex_req_i),
        .hilo_fwd_i (hilo_fwd),
        .wb_o       (ex_wb),
        .hilo_wr_o  (ex_hilo_wr)
    );

    // Pipeline register and HI/LO.
    ex_mem u_ex_mem (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_i       (ex_wb),
        .hilo_wr_i  (ex_hilo_wr),
        .wb_o       (wb_o),
        .hilo_o     (hilo_o),
        .hilo_fwd_o (hilo_fwd)
    );

endmodule

// File: verilog/exe_pkg.sv
package exe_pkg;

    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 2 * WORD_W;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [DWORD_W-1:0]    dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    // **********************************************************
    // Operation codes.
    // **********************************************************
    typedef enum logic [ALU_OP_W-1:0] {
        OP_NOP    = 8'b0000_0000,
        OP_AND    = 8'b0010_0100,
        OP_OR     = 8'b0010_0101,
        OP_XOR    = 8'b0010_0110,
        OP_NOR    = 8'b0010_0111,
        OP_ANDI   = 8'b0101_1001,
        OP_ORI    = 8'b0101_1010,
        OP_XORI   = 8'b0101_1011,
        OP_SLL    = 8'b0111_1100,
        OP_SLLV   = 8'b0000_0100,
        OP_SRL    = 8'b0000_0010,
        OP_SRLV   = 8'b0000_0110,
        OP_SRA    = 8'b0000_0011,
        OP_SRAV   = 8'b0000_0111,
        OP_MOVZ   = 8'b0000_1010,
        OP_MOVN   = 8'b0000_1011,
        OP_MFHI   = 8'b0001_0000,
        OP_MTHI   = 8'b0001_0001,
        OP_MFLO   = 8'b0001_0010,
        OP_MTLO   = 8'b0001_0011,
        OP_SLT    = 8'b0010_1010,
        OP_SLTU   = 8'b0010_1011,
        OP_SLTI   = 8'b0101_0111,
        OP_SLTIU  = 8'b0101_1000,
        OP_ADD    = 8'b0010_0000,
        OP_ADDU   = 8'b0010_0001,
        OP_SUB    = 8'b0010_0010,
        OP_SUBU   = 8'b0010_0011,
        OP_ADDI   = 8'b0101_0101,
        OP_ADDIU  = 8'b0101_0110,
        OP_CLZ    = 8'b1011_0000,
        OP_CLO    = 8'b1011_0001,
        OP_MULT   = 8'b0001_1000,
        OP_MULTU  = 8'b0001_1001,
        OP_MUL    = 8'b1010_1001,
        OP_JAL    = 8'b0101_0000,
        OP_JALR   = 8'b0000_1001,
        OP_BLTZAL = 8'b0100_1010,
        OP_BGEZAL = 8'b0100_1011
    } alu_op_e;

    typedef enum logic [ALU_SEL_W-1:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_MOVE        = 3'b011,
        SEL_ARITHMETIC  = 3'b100,
        SEL_MUL         = 3'b101,
        SEL_JUMP_BRANCH = 3'b110
    } alu_sel_e;

    // **********************************************************
    // Stage payloads.
    // **********************************************************
    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
    } ex_req_t;

    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } wb_req_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

endpackage
